//--- cluster_route_pkg.sv
package cluster_route_pkg;

	typedef logic [15:0] word_t; // one table word
	typedef logic [9:0] addr_t; // word address
	typedef logic [7:0] idx_t; // neighbor or sink index
	typedef logic [15:0] q_t; // unsigned 11.5
	typedef logic [15:0] batt_t; // 1.15
	typedef logic [15:0] hcm_t; // 3.13

	localparam int table_depth = 1024; // words in the node table

	// each array below holds up to 64 entries
	localparam addr_t known_sinks_base = 10'h000; // sink ids
	localparam addr_t neighbor_id_base = 10'h040; // neighbor ids
	localparam addr_t cluster_id_base = 10'h080; // neighbor cluster ids
	localparam addr_t battery_base = 10'h0C0; // neighbor battery levels
	localparam addr_t q_value_base = 10'h100; // neighbor q-values
	localparam addr_t hcm_base = 10'h140; // hcm table, up to 16 words
	localparam addr_t better_list_base = 10'h180; // output list
	localparam addr_t known_sink_count_addr = 10'h1C0;
	localparam addr_t neighbor_count_addr = 10'h1C1;
	localparam addr_t better_count_addr = 10'h1C2;

	localparam batt_t battery_threshold = 16'h0148; // about 0.01
	localparam idx_t no_hop_idx = 8'd65; // none found
	localparam q_t best_value_init = 16'hFFFE;
	localparam word_t no_neighbor_id = 16'h0FFE;

	typedef enum logic [3:0] {
		idle,
		wait_start,
		read_sink_count,
		read_neighbor_count,
		check_cluster,
		check_battery,
		check_q,
		scale_wait,
		read_id,
		match_sink,
		read_best_id,
		write_count,
		finish
	} scan_state_t;

endpackage

//--- node_table_ram.sv
`timescale 1ns/1ps

module node_table_ram import cluster_route_pkg::*; (
	input logic clock,
	// host side
	input logic host_wr,
	input addr_t host_addr,
	input word_t host_wdata,
	output word_t host_rdata,
	// engine side
	input logic mem_wr,
	input addr_t mem_addr,
	input word_t mem_wdata,
	output word_t mem_rdata
);

	word_t mem [table_depth]; // shared node table

	// engine write wins a collision
	always_ff @(posedge clock) begin
		if (mem_wr) begin
			mem[mem_addr] <= mem_wdata; // list and count writes
		end else if (host_wr) begin
			mem[host_addr] <= host_wdata; // table loading
		end
	end

	// both read ports are asynchronous
	assign host_rdata = mem[host_addr]; // readback after done
	assign mem_rdata = mem[mem_addr]; // valid in the state after the address

endmodule

//--- scan_index_counter.sv
`timescale 1ns/1ps

module scan_index_counter import cluster_route_pkg::*; (
	input logic clock,
	input logic nrst,
	input logic load_counts,
	input word_t count_word,
	input logic clear_i,
	input logic step_i,
	input logic clear_j,
	input logic step_j,
	output idx_t nbr_idx,
	output idx_t sink_idx,
	output logic last_nbr,
	output logic last_sink
);

	idx_t nbr_count; // neighbors in table
	idx_t sink_count; // known sinks in table
	logic sink_loaded; // first load done, next one is the neighbor count

	always_ff @(posedge clock) begin
		if (!nrst) begin
			nbr_idx <= '0;
			sink_idx <= '0;
			nbr_count <= '0;
			sink_count <= '0;
			sink_loaded <= 1'b0;
		end else begin
			if (clear_i) begin
				nbr_idx <= '0;
				sink_loaded <= 1'b0; // next load is the sink count
			end else if (step_i) begin
				nbr_idx <= nbr_idx + 8'd1;
			end
			if (clear_j) begin
				sink_idx <= '0;
			end else if (step_j) begin
				sink_idx <= sink_idx + 8'd1;
			end
			if (load_counts) begin
				if (!sink_loaded) sink_count <= count_word[7:0];
				else nbr_count <= count_word[7:0];
				sink_loaded <= ~sink_loaded;
			end
		end
	end

	// 9 bit compare so that a zero count reads as last
	assign last_nbr = ({1'b0, nbr_idx} + 9'd1) >= {1'b0, nbr_count};
	assign last_sink = ({1'b0, sink_idx} + 9'd1) >= {1'b0, sink_count};

endmodule

//--- hop_cost_scaler.sv
`timescale 1ns/1ps

module hop_cost_scaler import cluster_route_pkg::*; #(
	parameter int hcm_length = 11
) (
	input logic clock,
	input logic nrst,
	input logic clear,
	input logic scale_go,
	input idx_t nbr_idx,
	input batt_t batt_word,
	input q_t q_word,
	input hcm_t hcm_word,
	output logic hcm_req,
	output idx_t hcm_sel,
	output logic scale_done,
	output idx_t best_hop,
	output q_t best_value
);

	localparam logic [3:0] hcm_max = 4'(hcm_length - 1); // last hcm index

	logic [1:0] phase; // 0 idle, 1 ceil, 2 fetch and multiply, 3 compare
	logic [19:0] batt_prod; // 5.15
	q_t q_hold;
	idx_t idx_hold; // neighbor under evaluation
	q_t scaled_q; // q times hcm, back in 11.5
	logic [31:0] q_prod; // 14.18
	logic [5:0] ceil_idx;

	// ceiling of the integer part, one step up on any fraction
	assign ceil_idx = {1'b0, batt_prod[19:15]} + {5'd0, |batt_prod[14:0]};
	assign q_prod = {16'd0, q_hold} * {16'd0, hcm_word};
	assign hcm_req = (phase == 2'd2); // hcm word valid this cycle

	always_ff @(posedge clock) begin
		if (!nrst || clear) begin
			phase <= 2'd0;
			scale_done <= 1'b0;
			best_hop <= no_hop_idx;
			best_value <= best_value_init;
		end else begin
			scale_done <= 1'b0; // single cycle pulse
			case (phase)
				2'd0: if (scale_go) begin
					batt_prod <= {4'd0, batt_word} * {16'd0, hcm_max}; // 4.0 x 1.15
					q_hold <= q_word;
					idx_hold <= nbr_idx;
					phase <= 2'd1;
				end
				2'd1: begin
					// clamp to the top of the table
					if (ceil_idx > {2'b00, hcm_max}) hcm_sel <= {4'd0, hcm_max};
					else hcm_sel <= {2'b00, ceil_idx};
					phase <= 2'd2;
				end
				2'd2: begin
					scaled_q <= q_prod[28:13]; // truncate to 11.5
					phase <= 2'd3;
				end
				default: begin
					if (scaled_q < best_value) begin // strict, first of ties stays
						best_value <= scaled_q;
						best_hop <= idx_hold;
					end
					scale_done <= 1'b1;
					phase <= 2'd0;
				end
			endcase
		end
	end

endmodule

//--- neighbor_scan_fsm.sv
`timescale 1ns/1ps

module neighbor_scan_fsm import cluster_route_pkg::*; (
	input logic clock,
	input logic nrst,
	input logic en,
	input logic start,
	input word_t my_cluster_id,
	input q_t my_best,
	input word_t mem_rdata,
	input logic last_nbr,
	input logic last_sink,
	input idx_t nbr_idx,
	input idx_t sink_idx,
	input logic scale_done,
	input logic hcm_req,
	input idx_t hcm_sel,
	input idx_t best_hop,
	output addr_t mem_addr,
	output logic mem_wr,
	output word_t mem_wdata,
	output logic load_counts,
	output logic clear_i,
	output logic step_i,
	output logic clear_j,
	output logic step_j,
	output logic scale_go,
	output batt_t batt_word,
	output q_t q_word,
	output word_t best_neighbor_id,
	output idx_t next_sink,
	output idx_t better_count,
	output logic done
);

	scan_state_t state;
	addr_t addr_q; // address for the next state
	word_t cluster_q; // my_cluster_id held for the scan
	q_t best_q; // my_best held for the scan
	word_t id_q; // current neighbor id
	logic have_sinks; // sink count nonzero
	logic advance; // current neighbor finished
	scan_state_t adv_state;
	addr_t adv_addr;

	// scaler owns the port while it fetches the hcm word
	assign mem_addr = (state == scale_wait && hcm_req) ? hcm_base + addr_t'(hcm_sel) : addr_q;

	assign advance = (state == check_cluster && mem_rdata != cluster_q)
		|| (state == check_battery && mem_rdata < battery_threshold)
		|| (state == read_id && !have_sinks)
		|| (state == match_sink && last_sink);
	assign adv_state = last_nbr ? read_best_id : check_cluster;
	assign adv_addr = last_nbr ? neighbor_id_base + addr_t'(best_hop)
		: cluster_id_base + addr_t'(nbr_idx) + addr_t'(1);

	assign load_counts = (state == read_sink_count) || (state == read_neighbor_count);
	assign clear_i = (state == idle) && en; // also clears the scaler
	assign step_i = advance && !last_nbr;
	assign clear_j = clear_i || (state == match_sink && last_sink);
	assign step_j = (state == match_sink) && !last_sink;

	always_ff @(posedge clock) begin
		if (!nrst) begin
			state <= idle;
			addr_q <= known_sink_count_addr;
			mem_wr <= 1'b0;
			scale_go <= 1'b0;
			done <= 1'b0;
			have_sinks <= 1'b0;
			best_neighbor_id <= no_neighbor_id;
			next_sink <= no_hop_idx;
			better_count <= '0;
		end else begin
			mem_wr <= 1'b0; // every write is one cycle
			scale_go <= 1'b0;
			if (advance) begin
				state <= adv_state;
				addr_q <= adv_addr;
			end
			case (state)
				idle: if (en) begin // done holds here until en
					done <= 1'b0;
					best_neighbor_id <= no_neighbor_id;
					next_sink <= no_hop_idx;
					better_count <= '0;
					state <= wait_start;
				end
				wait_start: if (start) begin
					cluster_q <= my_cluster_id;
					best_q <= my_best;
					addr_q <= known_sink_count_addr;
					state <= read_sink_count;
				end
				read_sink_count: begin
					have_sinks <= (mem_rdata != '0);
					addr_q <= neighbor_count_addr;
					state <= read_neighbor_count;
				end
				read_neighbor_count: begin
					if (mem_rdata == '0) begin // empty table, straight to close
						addr_q <= neighbor_id_base + addr_t'(best_hop);
						state <= read_best_id;
					end else begin
						addr_q <= cluster_id_base; // index is still 0
						state <= check_cluster;
					end
				end
				check_cluster: if (!advance) begin
					addr_q <= battery_base + addr_t'(nbr_idx);
					state <= check_battery;
				end
				check_battery: if (!advance) begin
					batt_word <= mem_rdata;
					addr_q <= q_value_base + addr_t'(nbr_idx);
					state <= check_q;
				end
				check_q: begin
					if (q_t'(mem_rdata) <= best_q) begin // better neighbor
						mem_wr <= 1'b1;
						mem_wdata <= {8'd0, nbr_idx};
						addr_q <= better_list_base + addr_t'(better_count);
						better_count <= better_count + 8'd1;
						q_word <= mem_rdata;
						scale_go <= 1'b1;
						state <= scale_wait;
					end else begin
						addr_q <= neighbor_id_base + addr_t'(nbr_idx); // still a sink candidate
						state <= read_id;
					end
				end
				scale_wait: if (scale_done) begin
					addr_q <= neighbor_id_base + addr_t'(nbr_idx);
					state <= read_id;
				end
				read_id: if (!advance) begin
					id_q <= mem_rdata;
					addr_q <= known_sinks_base + addr_t'(sink_idx);
					state <= match_sink;
				end
				match_sink: begin
					if (mem_rdata == id_q) next_sink <= nbr_idx; // later match wins
					if (!last_sink) addr_q <= known_sinks_base + addr_t'(sink_idx) + addr_t'(1);
				end
				read_best_id: begin
					if (best_hop != no_hop_idx) best_neighbor_id <= mem_rdata;
					mem_wr <= 1'b1;
					mem_wdata <= {8'd0, better_count};
					addr_q <= better_count_addr;
					state <= write_count;
				end
				write_count: state <= finish;
				finish: begin
					done <= 1'b1;
					state <= idle;
				end
				default: state <= idle;
			endcase
		end
	end

endmodule

//--- cluster_route_core.sv
`timescale 1ns/1ps

module cluster_route_core import cluster_route_pkg::*; #(
	parameter int hcm_length = 11 // words in the hcm table, 2 to 16
) (
	input logic clock,
	input logic nrst,
	input logic en,
	input logic start,
	input word_t my_cluster_id,
	input q_t my_best,
	input logic host_wr,
	input addr_t host_addr,
	input word_t host_wdata,
	output word_t host_rdata,
	output idx_t best_hop,
	output q_t best_value,
	output word_t best_neighbor_id,
	output idx_t next_sink,
	output idx_t better_count,
	output logic done
);

	addr_t mem_addr;
	logic mem_wr;
	word_t mem_wdata;
	word_t mem_rdata; // also the count word and the hcm word
	logic load_counts, clear_i, step_i, clear_j, step_j;
	idx_t nbr_idx, sink_idx;
	logic last_nbr, last_sink;
	logic scale_go, scale_done, hcm_req;
	idx_t hcm_sel;
	batt_t batt_word;
	q_t q_word;

	node_table_ram u_node_table_ram (.clock, .host_wr, .host_addr, .host_wdata, .host_rdata,
		.mem_wr, .mem_addr, .mem_wdata, .mem_rdata);

	neighbor_scan_fsm u_neighbor_scan_fsm (.clock, .nrst, .en, .start, .my_cluster_id,
		.my_best, .mem_rdata, .last_nbr, .last_sink, .nbr_idx, .sink_idx, .scale_done,
		.hcm_req, .hcm_sel, .best_hop, .mem_addr, .mem_wr, .mem_wdata, .load_counts,
		.clear_i, .step_i, .clear_j, .step_j, .scale_go, .batt_word, .q_word,
		.best_neighbor_id, .next_sink, .better_count, .done);

	scan_index_counter u_scan_index_counter (.clock, .nrst, .load_counts,
		.count_word(mem_rdata), .clear_i, .step_i, .clear_j, .step_j, .nbr_idx,
		.sink_idx, .last_nbr, .last_sink);

	hop_cost_scaler #(.hcm_length(hcm_length)) u_hop_cost_scaler (.clock, .nrst,
		.clear(clear_i), .scale_go, .nbr_idx, .batt_word, .q_word, .hcm_word(mem_rdata),
		.hcm_req, .hcm_sel, .scale_done, .best_hop, .best_value);

endmodule

//--- cluster_route_core_asserts.sv
`timescale 1ns/1ps

module cluster_route_core_asserts (
	input logic clock,
	input logic nrst,
	input logic en,
	input logic done,
	input logic mem_wr,
	input logic scale_go,
	input logic scale_done
);

	int fail_count = 0; // watched by the testbench
	logic scale_busy; // scaler holds a job

	always_ff @(posedge clock) begin
		if (!nrst) begin
			scale_busy <= 1'b0;
		end else if (scale_done) begin
			scale_busy <= 1'b0; // job returned
		end else if (scale_go) begin
			scale_busy <= 1'b1;
		end
	end

	done_held: assert property (@(posedge clock) disable iff (!nrst) done && !en |=> done)
		else begin
			fail_count++;
			$error("done fell before en");
		end

	single_write: assert property (@(posedge clock) disable iff (!nrst) mem_wr |=> !mem_wr)
		else begin
			fail_count++;
			$error("mem_wr held for more than one cycle");
		end

	one_scale: assert property (@(posedge clock) disable iff (!nrst) scale_go |-> !scale_busy)
		else begin
			fail_count++;
			$error("scale_go while the scaler is busy");
		end

endmodule

bind neighbor_scan_fsm cluster_route_core_asserts u_fsm_asserts (.clock, .nrst, .en, .done,
	.mem_wr, .scale_go, .scale_done);

//--- tb_cluster_route_core.sv
`timescale 1ns/1ps

module tb_cluster_route_core import cluster_route_pkg::*; ();

	logic clock;
	logic nrst, en, start, host_wr, done;
	word_t my_cluster_id, host_wdata, host_rdata, best_neighbor_id;
	q_t my_best, best_value;
	addr_t host_addr;
	idx_t best_hop, next_sink, better_count;

	word_t stim [0:255]; // data file image
	int cycle_limit; // scan cycles allowed over the whole run
	int scan_cycles; // scan cycles used so far
	logic scan_busy; // between start and done

	cluster_route_core u_cluster_route_core (.clock, .nrst, .en, .start, .my_cluster_id,
		.my_best, .host_wr, .host_addr, .host_wdata, .host_rdata, .best_hop, .best_value,
		.best_neighbor_id, .next_sink, .better_count, .done);

	always #50 clock = ~clock; // 100 ns period

	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("CHECKS FAILED");
		$fatal(1, "run stopped at %0t ns", $time);
	endtask

	task automatic check_idx(input string name, input idx_t got, input idx_t exp);
		if (got !== exp) stop_on_error($sformatf("mismatch at %0t ns: %s is %h, expected %h",
			$time, name, got, exp));
	endtask

	task automatic check_q(input string name, input q_t got, input q_t exp);
		if (got !== exp) stop_on_error($sformatf("mismatch at %0t ns: %s is %h, expected %h",
			$time, name, got, exp));
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) stop_on_error($sformatf("mismatch at %0t ns: %s is %h, expected %h",
			$time, name, got, exp));
	endtask

	// sum of neighbors times (sinks + 12), plus 20 per scenario
	function automatic int scan_cycle_limit();
		int p;
		int n;
		int k;
		int sinks;
		int nbrs;
		int limit;
		p = 0;
		sinks = 0;
		nbrs = 0;
		limit = 0;
		while (p < 240 && !$isunknown(stim[p]) && stim[p] != 16'hFFFF) begin
			n = int'(stim[p]);
			for (k = 0; k < n; k++) begin
				if (addr_t'(stim[p + 3 + 2 * k]) == known_sink_count_addr)
					sinks = int'(stim[p + 4 + 2 * k][7:0]); // counts persist in the table
				if (addr_t'(stim[p + 3 + 2 * k]) == neighbor_count_addr)
					nbrs = int'(stim[p + 4 + 2 * k][7:0]);
			end
			p = p + 3 + 2 * n; // now at the expected results
			limit += nbrs * (sinks + 12) + 20;
			p = p + 5 + int'(stim[p]); // results plus the list
		end
		return limit;
	endfunction

	task automatic host_write(input addr_t addr, input word_t data);
		@(negedge clock);
		host_wr = 1'b1;
		host_addr = addr;
		host_wdata = data;
	endtask

	task automatic read_table(input addr_t addr, output word_t data);
		@(negedge clock);
		host_wr = 1'b0;
		host_addr = addr;
		@(negedge clock);
		data = host_rdata; // combinational read, settled by now
	endtask

	task automatic run_scan(input word_t cluster, input q_t best);
		@(negedge clock);
		host_wr = 1'b0;
		my_cluster_id = cluster;
		my_best = best;
		en = 1'b1; // clears the old results
		@(negedge clock);
		en = 1'b0;
		start = 1'b1;
		@(negedge clock);
		start = 1'b0;
		scan_busy = 1'b1;
		while (!done) @(negedge clock);
		scan_busy = 1'b0;
	endtask

	always @(posedge clock) begin
		if (scan_busy) begin
			scan_cycles++;
			if (scan_cycles > cycle_limit) stop_on_error($sformatf(
				"timeout, done did not rise within %0d scan cycles", cycle_limit));
		end
	end

	always @(negedge clock) begin
		if (u_cluster_route_core.u_neighbor_scan_fsm.u_fsm_asserts.fail_count != 0)
			stop_on_error("an engine protocol assertion failed");
	end

	initial begin
		int p;
		int n;
		int k;
		int scenario;
		word_t rd;
		clock = 1'b0;
		nrst = 1'b0;
		en = 1'b0;
		start = 1'b0;
		my_cluster_id = '0;
		my_best = '0;
		host_wr = 1'b0;
		host_addr = '0;
		host_wdata = '0;
		scan_busy = 1'b0;
		scan_cycles = 0;
		$readmemh("cluster_route_core_input.txt", stim);
		cycle_limit = scan_cycle_limit();
		if (cycle_limit == 0) stop_on_error("the data file holds no scenario");
		repeat (4) @(negedge clock);
		nrst = 1'b1;
		p = 0;
		scenario = 0;
		while (stim[p] !== 16'hFFFF) begin
			if ($isunknown(stim[p]) || p > 240)
				stop_on_error("the data file ends without its FFFF terminator");
			n = int'(stim[p]);
			for (k = 0; k < n; k++) host_write(addr_t'(stim[p + 3 + 2 * k]), stim[p + 4 + 2 * k]);
			run_scan(stim[p + 1], q_t'(stim[p + 2]));
			p = p + 3 + 2 * n;
			check_idx("better_count", better_count, idx_t'(stim[p]));
			check_idx("best_hop", best_hop, idx_t'(stim[p + 1]));
			check_q("best_value", best_value, q_t'(stim[p + 2]));
			check_word("best_neighbor_id", best_neighbor_id, stim[p + 3]);
			check_idx("next_sink", next_sink, idx_t'(stim[p + 4]));
			read_table(better_count_addr, rd); // count word left in the table
			check_word("stored better count", rd, stim[p]);
			for (k = 0; k < int'(stim[p]); k++) begin
				read_table(better_list_base + addr_t'(k), rd);
				check_word($sformatf("better_list[%0d]", k), rd, stim[p + 5 + k]);
			end
			p = p + 5 + int'(stim[p]);
			scenario++;
			$display("scenario %0d done at %0t ns", scenario, $time);
		end
		@(negedge clock);
		if (u_cluster_route_core.u_neighbor_scan_fsm.u_fsm_asserts.fail_count != 0) begin
			stop_on_error("an engine protocol assertion failed");
		end else begin
			$display("ALL CHECKS PASSED");
			$finish;
		end
	end

endmodule

//--- cluster_route_core_input.txt
// per scenario: pair count, my_cluster_id, my_best, then address/data pairs
// then better_count best_hop best_value best_neighbor_id next_sink and the better list
// scenario 1: every filter, ceiling hcm index, two known sinks
0024 0003 0200
000 0A01 001 0A02 1C0 0002 1C1 0006
140 6000 141 5000 142 4800 143 4000 144 3800 145 3000
146 2C00 147 2800 148 2400 149 2200 14A 2000
040 0A02 041 0A01 042 0B02 043 0B03 044 0A01 045 0B05
080 0003 081 0004 082 0003 083 0003 084 0003 085 0003
0C0 4000 0C2 0147 0C3 4001 0C4 8000 0C5 0148
100 0100 103 0100 104 0300 105 0200
0003 0003 0160 0B03 0004
0000 0003 0005
// scenario 2: back to back, tie kept by the first, clamped index, no sink match
0005 0003 0180
000 0C00 1C0 0001 103 0181 0C5 C000 105 0180
0002 0000 0180 0A02 0041
0000 0005
// scenario 3: foreign cluster everywhere
0000 0007 0200
0000 0041 FFFE 0FFE 0041
// scenario 4: no known sinks, two neighbors
0002 0003 0200
1C0 0000 1C1 0002
0001 0000 0180 0A02 0041
0000
// scenario 5: empty neighbor table
0001 0003 0200
1C1 0000
0000 0041 FFFE 0FFE 0041
FFFF

//--- cluster_route_core.f
cluster_route_pkg.sv
node_table_ram.sv
scan_index_counter.sv
hop_cost_scaler.sv
neighbor_scan_fsm.sv
cluster_route_core.sv
cluster_route_core_asserts.sv
tb_cluster_route_core.sv
